// File: mult_cfg.svh
// Word width and half-word split of the multiply unit
// Operand halves carry one extra bit for the sign, so they are MULT_HALF+1 wide

`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// Operand and result width
`define MULT_XLEN 32

// Split point between low and high operand halves
`define MULT_HALF 16

`endif

// File: mult_isa_pkg.sv
// Instruction level types of the multiply unit
// Opcode selecting low or high product, and the operand sign mode

package mult_isa_pkg;

  // Which half of the 64-bit product is returned
  typedef enum logic {
    MUL_M32 = 1'b0,  // Low word, single cycle
    MUL_H   = 1'b1   // High word, four step schedule
  } mul_opcode_e;

  // Bit 0 marks operand A signed, bit 1 marks operand B signed
  typedef enum logic [1:0] {
    SIGN_UU = 2'b00,  // MULHU
    SIGN_SU = 2'b01,  // MULHSU
    SIGN_SS = 2'b11   // MULH
  } sign_mode_e;

endpackage

// File: mult_dp_pkg.sv
// Datapath types of the multiply unit
// Step state of the high product schedule and partial product widths

`include "mult_cfg.svh"

package mult_dp_pkg;

  // Four steps of the 17x17 shift and add schedule
  typedef enum logic [1:0] {
    MUL_ALBL = 2'b00,  // al * bl, also idle
    MUL_ALBH = 2'b01,  // al * bh
    MUL_AHBL = 2'b10,  // ah * bl
    MUL_AHBH = 2'b11   // ah * bh, result step
  } mul_state_e;

  // Signed 17x17 product
  localparam int PP_W  = 2 * (`MULT_HALF + 1);

  // Running sum between steps, one bit below the product width
  localparam int ACC_W = PP_W - 1;

endpackage

// File: mult_step_if.sv
// Per-step control bundle from the multiply sequencer to the datapath
// State plus accumulator clear, load, freeze and final step select

`timescale 1ns/10ps

interface mult_step_if;

  mult_dp_pkg::mul_state_e state;       // Current schedule step
  logic                    acc_clr;     // Zero the accumulator next edge
  logic                    acc_en;      // Load the next partial sum
  logic                    hold;        // Freeze accumulator on halt or stall
  logic                    final_step;  // Last step selects the sum as result

  // Sequencer side drives every control
  modport seq (
    output state,
    output acc_clr,
    output acc_en,
    output hold,
    output final_step
  );

  // Datapath side only listens
  modport dp (
    input  state,
    input  acc_clr,
    input  acc_en,
    input  hold,
    input  final_step
  );

endinterface

// File: mult_seq.sv
// Step sequencer of the multiply unit
// High product state machine, valid/ready handshake, halt and kill

`timescale 1ns/10ps

module mult_seq (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      valid_i,     // Request from EX
  input  mult_isa_pkg::mul_opcode_e operator_i,
  input  logic                      ready_i,     // Consumer can take result
  input  logic                      halt_i,      // Pipeline stall
  input  logic                      kill_i,      // Pipeline flush
  output logic                      ready_o,     // Request may leave
  output logic                      valid_o,     // Result qualified
  mult_step_if.seq                  step
);

  mult_dp_pkg::mul_state_e state_q;
  mult_dp_pkg::mul_state_e state_d;
  logic                    is_mulh;   // High product request present

  assign is_mulh = valid_i && (operator_i == mult_isa_pkg::MUL_H);

  ////////////////////////////////////////////////////////////////////////////
  // State register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= mult_dp_pkg::MUL_ALBL;
    end else begin
      state_q <= state_d;
    end
  end

  assign step.state      = state_q;
  assign step.final_step = (state_q == mult_dp_pkg::MUL_AHBH);

  ////////////////////////////////////////////////////////////////////////////
  // Next state, handshake and accumulator control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    valid_o      = 1'b0;
    ready_o      = 1'b0;
    step.acc_en  = 1'b0;
    step.acc_clr = 1'b0;
    step.hold    = 1'b0;

    if (kill_i) begin
      // Flush wins over everything, drop back to idle
      state_d      = mult_dp_pkg::MUL_ALBL;
      step.acc_clr = 1'b1;
      ready_o      = 1'b1;
    end else if (halt_i) begin
      step.hold = 1'b1;  // Freeze, resume in same step later
    end else begin
      case (state_q)
        mult_dp_pkg::MUL_ALBL: begin
          if (!valid_i) begin
            ready_o = 1'b1;       // Idle
          end else if (!is_mulh) begin
            valid_o = 1'b1;       // MUL done in this cycle
            ready_o = ready_i;
          end else begin
            step.acc_en = 1'b1;   // Store al*bl >> 16
            state_d     = mult_dp_pkg::MUL_ALBH;
          end
        end
        mult_dp_pkg::MUL_ALBH: begin
          if (is_mulh) begin
            step.acc_en = 1'b1;
            state_d     = mult_dp_pkg::MUL_AHBL;
          end
        end
        mult_dp_pkg::MUL_AHBL: begin
          if (is_mulh) begin
            step.acc_en = 1'b1;   // Sum shifted down for the top step
            state_d     = mult_dp_pkg::MUL_AHBH;
          end
        end
        default: begin
          // MUL_AHBH, result waits here for the consumer
          valid_o = valid_i;
          ready_o = ready_i;
          if (valid_i && ready_i) begin
            state_d      = mult_dp_pkg::MUL_ALBL;
            step.acc_clr = 1'b1;
          end else begin
            step.hold = 1'b1;     // Back-pressure
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake checks
  ////////////////////////////////////////////////////////////////////////////

  // Requester may not swap the opcode of a stalled request
  a_operator_stable : assert property (@(posedge clk) disable iff (rst_i)
    (valid_i && !ready_o) ##1 valid_i |-> $stable(operator_i))
    else $error("mult_seq: operator changed while request stalled");

  a_valid_qualified : assert property (@(posedge clk) disable iff (rst_i)
    valid_o |-> valid_i)
    else $error("mult_seq: valid_o without valid_i");

  // Consumed result must free the input side in the same cycle
  a_ready_on_accept : assert property (@(posedge clk) disable iff (rst_i)
    (valid_o && ready_i) |-> ready_o)
    else $error("mult_seq: result taken but ready_o low");

  a_kill_to_idle : assert property (@(posedge clk) disable iff (rst_i)
    kill_i |=> (state_q == mult_dp_pkg::MUL_ALBL))
    else $error("mult_seq: kill did not return to MUL_ALBL");

endmodule

// File: mult_datapath.sv
// Multiply datapath with operand halving and the 17x17 signed multiplier
// Accumulator for the high product schedule and the single cycle low product

`timescale 1ns/10ps
`include "mult_cfg.svh"

module mult_datapath (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic [`MULT_XLEN-1:0]     op_a_i,
  input  logic [`MULT_XLEN-1:0]     op_b_i,
  input  mult_isa_pkg::mul_opcode_e operator_i,
  input  mult_isa_pkg::sign_mode_e  signed_mode_i,
  mult_step_if.dp                   step,
  output logic [`MULT_XLEN-1:0]     result_o
);

  localparam int XLEN  = `MULT_XLEN;
  localparam int HALF  = `MULT_HALF;
  localparam int HW    = HALF + 1;              // Partial operand width
  localparam int PP_W  = mult_dp_pkg::PP_W;
  localparam int ACC_W = mult_dp_pkg::ACC_W;

  logic             sign_a;      // A high half is negative
  logic             sign_b;
  logic [HW-1:0]    al, bl, ah, bh;
  logic [HW-1:0]    mul_a, mul_b;
  logic [PP_W-1:0]  int_result;  // Current partial product
  logic [PP_W-1:0]  step_sum;    // Partial product plus running sum
  logic [PP_W-1:0]  ll_shift;
  logic [PP_W-1:0]  hl_shift;
  logic [ACC_W-1:0] mulh_acc;
  logic [ACC_W-1:0] acc_next;
  logic [XLEN-1:0]  mul_low;

  ////////////////////////////////////////////////////////////////////////////
  // Operand halves
  ////////////////////////////////////////////////////////////////////////////

  assign sign_a = signed_mode_i[0] & op_a_i[XLEN-1];
  assign sign_b = signed_mode_i[1] & op_b_i[XLEN-1];

  assign al = {1'b0, op_a_i[HALF-1:0]};       // Low halves never signed
  assign bl = {1'b0, op_b_i[HALF-1:0]};
  assign ah = {sign_a, op_a_i[XLEN-1:HALF]};
  assign bh = {sign_b, op_b_i[XLEN-1:HALF]};

  // Pair for this step
  always_comb begin
    case (step.state)
      mult_dp_pkg::MUL_ALBL: begin
        mul_a = al;
        mul_b = bl;
      end
      mult_dp_pkg::MUL_ALBH: begin
        mul_a = al;
        mul_b = bh;
      end
      mult_dp_pkg::MUL_AHBL: begin
        mul_a = ah;
        mul_b = bl;
      end
      default: begin
        mul_a = ah;
        mul_b = bh;
      end
    endcase
  end

  assign int_result = $signed(mul_a) * $signed(mul_b);
  assign step_sum   = $signed(int_result) + $signed({mulh_acc[ACC_W-1], mulh_acc});

  ////////////////////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////////////////////

  assign ll_shift = int_result >> HALF;           // al*bl is never negative
  assign hl_shift = $signed(step_sum) >>> HALF;   // Keep sign for top step

  always_comb begin
    case (step.state)
      mult_dp_pkg::MUL_ALBL: acc_next = ll_shift[ACC_W-1:0];
      mult_dp_pkg::MUL_ALBH: acc_next = step_sum[ACC_W-1:0];
      mult_dp_pkg::MUL_AHBL: acc_next = hl_shift[ACC_W-1:0];
      default:               acc_next = mulh_acc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_i || step.acc_clr) begin
      mulh_acc <= '0;
    end else if (step.acc_en && !step.hold) begin
      mulh_acc <= acc_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  assign mul_low = op_a_i * op_b_i;  // Low word same for any sign mode

  always_comb begin
    if (operator_i == mult_isa_pkg::MUL_M32) begin
      result_o = mul_low;
    end else if (step.final_step) begin
      result_o = step_sum[XLEN-1:0];   // ah*bh plus carried sum
    end else begin
      result_o = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Step checks
  ////////////////////////////////////////////////////////////////////////////

  logic [2*XLEN-1:0] ref_prod;   // Full product from extended operands
  logic [XLEN-1:0]   ref_word;
  logic [PP_W-1:0]   a_lo_x, a_hi_x, b_lo_x, b_hi_x;
  logic [PP_W-1:0]   exp_pp;

  assign ref_prod = {{XLEN{sign_a}}, op_a_i} * {{XLEN{sign_b}}, op_b_i};
  assign ref_word = (operator_i == mult_isa_pkg::MUL_M32) ? ref_prod[XLEN-1:0]
                                                          : ref_prod[2*XLEN-1:XLEN];

  // Field products modulo 2**PP_W, independent of the 17-bit path
  assign a_lo_x = {{(PP_W-HALF){1'b0}}, op_a_i[HALF-1:0]};
  assign b_lo_x = {{(PP_W-HALF){1'b0}}, op_b_i[HALF-1:0]};
  assign a_hi_x = {{(PP_W-HALF){sign_a}}, op_a_i[XLEN-1:HALF]};
  assign b_hi_x = {{(PP_W-HALF){sign_b}}, op_b_i[XLEN-1:HALF]};

  always_comb begin
    case (step.state)
      mult_dp_pkg::MUL_ALBL: exp_pp = a_lo_x * b_lo_x;
      mult_dp_pkg::MUL_ALBH: exp_pp = a_lo_x * b_hi_x;
      mult_dp_pkg::MUL_AHBL: exp_pp = a_hi_x * b_lo_x;
      default:               exp_pp = a_hi_x * b_hi_x;
    endcase
  end

  // Low word for MUL, and the full four step sum for the high forms
  a_result_model : assert property (@(posedge clk) disable iff (rst_i)
    ((operator_i == mult_isa_pkg::MUL_M32) || step.final_step) |-> (result_o == ref_word))
    else $error("mult_datapath: result differs from 64-bit product");

  a_acc_zero_idle : assert property (@(posedge clk) disable iff (rst_i)
    (step.state == mult_dp_pkg::MUL_ALBL) |-> (mulh_acc == '0))
    else $error("mult_datapath: accumulator not zero at schedule start");

  a_step_product : assert property (@(posedge clk) disable iff (rst_i)
    ((operator_i == mult_isa_pkg::MUL_H) && (step.acc_en || step.final_step))
    |-> (int_result == exp_pp))
    else $error("mult_datapath: wrong partial product for step");

  // Consecutive busy steps belong to one request
  a_operands_stable : assert property (@(posedge clk) disable iff (rst_i)
    (step.state != mult_dp_pkg::MUL_ALBL) ##1 (step.state != mult_dp_pkg::MUL_ALBL)
    |-> ($stable(op_a_i) && $stable(op_b_i) && $stable(signed_mode_i)))
    else $error("mult_datapath: operands changed during high product");

  a_result_stable : assert property (@(posedge clk) disable iff (rst_i)
    (step.final_step && step.hold) ##1 step.final_step |-> $stable(result_o))
    else $error("mult_datapath: result moved under back-pressure");

endmodule

// File: mult_top.sv
// Multiply unit top level
// Sequencer and datapath joined by the step interface, plain ports outside

`timescale 1ns/10ps
`include "mult_cfg.svh"

module mult_top (
  input  logic                      clk,
  input  logic                      rst_i,
  // Request side
  input  logic                      valid_i,
  output logic                      ready_o,
  input  logic [`MULT_XLEN-1:0]     op_a_i,
  input  logic [`MULT_XLEN-1:0]     op_b_i,
  input  mult_isa_pkg::mul_opcode_e operator_i,
  input  mult_isa_pkg::sign_mode_e  signed_mode_i,
  // Pipeline controller
  input  logic                      halt_i,
  input  logic                      kill_i,
  // Result side
  output logic                      valid_o,
  input  logic                      ready_i,
  output logic [`MULT_XLEN-1:0]     result_o
);

  mult_step_if step_if ();   // Per-step control

  // Schedule and handshake
  mult_seq u_seq (
    .clk        (clk),
    .rst_i      (rst_i),
    .valid_i    (valid_i),
    .operator_i (operator_i),
    .ready_i    (ready_i),
    .halt_i     (halt_i),
    .kill_i     (kill_i),
    .ready_o    (ready_o),
    .valid_o    (valid_o),
    .step       (step_if.seq)
  );

  // Halves, multiplier and accumulator
  mult_datapath u_dp (
    .clk           (clk),
    .rst_i         (rst_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .step          (step_if.dp),
    .result_o      (result_o)
  );

endmodule

// File: tb_mult_top.sv
// Testbench for the multiply unit with a table of requests and expected results
// Covers MUL, MULH, MULHSU, MULHU with back-pressure, halt and kill

`timescale 1ns/10ps
`include "mult_cfg.svh"

module tb_mult_top;

  localparam int NUM_CORNER = 100;                  // 75 high forms + 25 MUL
  localparam int NUM_RAND   = 12;
  localparam int NUM_ROWS   = NUM_CORNER + NUM_RAND;
  localparam int MAX_BP     = 3;
  localparam int MAX_HALT   = 3;
  localparam int TIMEOUT    = NUM_ROWS * (4 + MAX_BP + MAX_HALT) + 100;

  // One request with its stall pattern and the model result
  typedef struct packed {
    mult_isa_pkg::mul_opcode_e op;
    mult_isa_pkg::sign_mode_e  mode;
    logic [`MULT_XLEN-1:0]     a;
    logic [`MULT_XLEN-1:0]     b;
    logic [`MULT_XLEN-1:0]     exp;
    logic [1:0]                bp;        // ready_i low cycles after valid_o
    logic [1:0]                halt_at;   // Request cycle where halt starts, 0 is none
    logic [1:0]                halt_len;
    logic                      kill;      // Flush once before the real run
  } row_t;

  logic                      clk;
  logic                      rst_i;
  logic                      valid_i;
  logic                      ready_o;
  logic [`MULT_XLEN-1:0]     op_a_i;
  logic [`MULT_XLEN-1:0]     op_b_i;
  mult_isa_pkg::mul_opcode_e operator_i;
  mult_isa_pkg::sign_mode_e  signed_mode_i;
  logic                      halt_i;
  logic                      kill_i;
  logic                      valid_o;
  logic                      ready_i;
  logic [`MULT_XLEN-1:0]     result_o;

  row_t   rows [NUM_ROWS];
  integer seed = 32'h47ae;
  int     cycle_cnt = 0;
  int     result_errs = 0;
  int     flag_errs = 0;

  mult_top i_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .valid_i       (valid_i),
    .ready_o       (ready_o),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .result_o      (result_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;   // 10 ns period

  // Hard stop sized from the table length
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout after %0d cycles, a request never completed", cycle_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // High or low word of the 64-bit product of the extended operands
  function automatic logic [`MULT_XLEN-1:0] model_result(
    input mult_isa_pkg::mul_opcode_e op, input mult_isa_pkg::sign_mode_e mode,
    input logic [31:0] a, input logic [31:0] b);
    logic        a_signed;
    logic        b_signed;
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    a_signed = (mode == mult_isa_pkg::SIGN_SS) || (mode == mult_isa_pkg::SIGN_SU);
    b_signed = (mode == mult_isa_pkg::SIGN_SS);
    ax       = {{32{a_signed & a[31]}}, a};
    bx       = {{32{b_signed & b[31]}}, b};
    prod     = ax * bx;   // Modulo 2**64 is exact for both signs
    return (op == mult_isa_pkg::MUL_M32) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic [31:0] corner_val(input int k);
    case (k)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hFFFF_FFFF;
      3:       return 32'h8000_0000;
      default: return 32'h7FFF_FFFF;
    endcase
  endfunction

  function automatic mult_isa_pkg::sign_mode_e mode_of(input int k);
    case (k)
      0:       return mult_isa_pkg::SIGN_UU;
      1:       return mult_isa_pkg::SIGN_SU;
      default: return mult_isa_pkg::SIGN_SS;
    endcase
  endfunction

  task automatic check_result(input string name, input logic [`MULT_XLEN-1:0] got,
                              input logic [`MULT_XLEN-1:0] exp);
    if (got !== exp) begin
      result_errs++;
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Table and request sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    int   n;
    row_t r;
    n = 0;
    for (int m = 0; m < 4; m++) begin    // m == 3 is the MUL block
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          r.op       = (m == 3) ? mult_isa_pkg::MUL_M32 : mult_isa_pkg::MUL_H;
          r.mode     = (m == 3) ? mode_of(j % 3) : mode_of(m);
          r.a        = corner_val(i);
          r.b        = corner_val(j);
          r.bp       = (m == 3) ? 2'(j % 2) : 2'((i + j) % 4);
          r.halt_at  = '0;
          r.halt_len = '0;
          r.kill     = 1'b0;
          rows[n]    = r;
          n++;
        end
      end
    end
    // Random operands, stall pattern picked by row index
    for (int k = 0; k < NUM_RAND; k++) begin
      r.op       = (k % 4 == 0) ? mult_isa_pkg::MUL_M32 : mult_isa_pkg::MUL_H;
      r.mode     = mode_of(k % 3);
      r.a        = $random(seed);
      r.b        = $random(seed);
      r.bp       = 2'(k % 4);
      r.halt_at  = (r.op == mult_isa_pkg::MUL_H && k % 3 == 1) ? 2'(1 + (k / 3) % 3) : 2'd0;
      r.halt_len = 2'(1 + (k / 4) % 3);
      r.kill     = (r.op == mult_isa_pkg::MUL_H) && (k % 3 == 2);
      rows[n]    = r;
      n++;
    end
    foreach (rows[q]) rows[q].exp = model_result(rows[q].op, rows[q].mode, rows[q].a, rows[q].b);
  endtask

  task automatic drive_request(input row_t r);
    valid_i       = 1'b1;
    op_a_i        = r.a;
    op_b_i        = r.b;
    operator_i    = r.op;
    signed_mode_i = r.mode;
  endtask

  // Start a high product, flush it in its second cycle
  task automatic kill_request(input row_t r);
    @(negedge clk);
    drive_request(r);
    #1;
    check_flag("valid_o", valid_o, 1'b0);
    @(negedge clk);
    kill_i = 1'b1;
    #1;
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);   // Flush frees the input side
  endtask

  task automatic apply_row(input row_t r);
    int cyc;
    int exp_cyc;
    bit done;
    exp_cyc = (r.op == mult_isa_pkg::MUL_M32) ? 1 : 4 + ((r.halt_at != 0) ? r.halt_len : 0);
    if (r.kill) kill_request(r);
    cyc  = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cyc++;
      kill_i  = 1'b0;
      drive_request(r);
      halt_i  = (r.halt_at != 0) && (cyc >= r.halt_at) && (cyc < r.halt_at + r.halt_len);
      ready_i = !((cyc >= exp_cyc) && (cyc < exp_cyc + r.bp));
      #1;
      check_flag("valid_o", valid_o, cyc >= exp_cyc);
      if (cyc >= exp_cyc) begin
        check_result("result_o", result_o, r.exp);   // Also holds under back-pressure
        check_flag("ready_o", ready_o, ready_i);
      end else if (r.op == mult_isa_pkg::MUL_H) begin
        check_flag("ready_o", ready_o, 1'b0);        // Busy or halted
      end
      done = valid_o && ready_i;
    end
    // One idle cycle between requests
    @(negedge clk);
    valid_i = 1'b0;
    halt_i  = 1'b0;
    ready_i = 1'b1;
    #1;
    check_flag("valid_o", valid_o, 1'b0);
    check_flag("ready_o", ready_o, 1'b1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_i         = 1'b1;
    valid_i       = 1'b0;
    op_a_i        = '0;
    op_b_i        = '0;
    operator_i    = mult_isa_pkg::MUL_M32;
    signed_mode_i = mult_isa_pkg::SIGN_UU;
    halt_i        = 1'b0;
    kill_i        = 1'b0;
    ready_i       = 1'b1;
    build_table();
    repeat (16) @(negedge clk);
    rst_i = 1'b0;
    #1;
    check_flag("valid_o", valid_o, 1'b0);   // Idle after reset
    check_flag("ready_o", ready_o, 1'b1);
    for (int k = 0; k < NUM_ROWS; k++) apply_row(rows[k]);
    $display("Done %0d rows: %0d result errors, %0d flag errors",
             NUM_ROWS, result_errs, flag_errs);
    if (result_errs + flag_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: mult.f
+incdir+.
mult_isa_pkg.sv
mult_dp_pkg.sv
mult_step_if.sv
mult_seq.sv
mult_datapath.sv
mult_top.sv
tb_mult_top.sv
